// ==== sources.f ====
src/axil_pkg.sv
src/clint_pkg.sv
src/clint_mtime.sv
src/clint_regs.sv
src/clint_read_fsm.sv
src/clint_write_fsm.sv
src/clint_top.sv
dv/clint_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the CLINT testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module clint_tb \
	--Mdir obj_dir -o Vclint_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vclint_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== dv/clint_tb.sv ====
// CLINT testbench; runs a table of AXI-Lite reads and writes against clint_top and checks the results
`timescale 1ns/10ps

module clint_tb;

	localparam axil_pkg::addr_t BASE     = 32'h0200_0000;
	localparam axil_pkg::addr_t A_MSIP   = BASE + clint_pkg::OFS_MSIP;
	localparam axil_pkg::addr_t A_CMP_LO = BASE + clint_pkg::OFS_MTIMECMP_LO;
	localparam axil_pkg::addr_t A_CMP_HI = BASE + clint_pkg::OFS_MTIMECMP_HI;
	localparam axil_pkg::addr_t A_TM_LO  = BASE + clint_pkg::OFS_MTIME_LO;
	localparam axil_pkg::addr_t A_TM_HI  = BASE + clint_pkg::OFS_MTIME_HI;
	localparam axil_pkg::addr_t A_BAD    = BASE + 32'h10;
	localparam axil_pkg::resp_t OK       = axil_pkg::RESP_OKAY;
	localparam axil_pkg::resp_t ERR      = axil_pkg::RESP_SLVERR;
	localparam int TICK_DIV      = 4;
	localparam int BUS_TIMEOUT   = 50;
	localparam int LEVEL_TIMEOUT = 1000;

	typedef enum logic {OP_RD, OP_WR} op_t;
	// exact compare, mtime bound, msip level, mtip level
	typedef enum logic [1:0] {K_EXACT, K_BOUND, K_MSIP, K_MTIP} kind_t;

	typedef struct packed {
		op_t             op;
		axil_pkg::addr_t addr;
		axil_pkg::data_t data;
		axil_pkg::strb_t strb;
		axil_pkg::data_t exp_data;
		axil_pkg::resp_t exp_resp;
		kind_t           kind;
	} step_t;

	logic              clk = 1'b0;
	logic              rst;
	axil_pkg::addr_t   araddr;
	logic              arvalid;
	logic              arready;
	axil_pkg::r_beat_t r;
	logic              rvalid;
	logic              rready;
	axil_pkg::addr_t   awaddr;
	logic              awvalid;
	logic              awready;
	axil_pkg::w_beat_t w;
	logic              wvalid;
	logic              wready;
	axil_pkg::resp_t   bresp;
	logic              bvalid;
	logic              bready;
	logic              msip;
	logic              mtip;
	int                cycle_cnt = 0;
	int                errors = 0;
	logic [31:0]       lfsr = 32'hddc5_6c9a;
	step_t             steps[$];

	clint_top i_dut (
		.clk, .rst,
		.araddr, .arvalid, .arready, .r, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .w, .wvalid, .wready,
		.bresp, .bvalid, .bready, .msip, .mtip
	);

	always #10 clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// galois LFSR, one step per bit taken
	function automatic int rand_bits(input int n);
		int   v;
		logic b;
		v = 0;
		for (int k = 0; k < n; k++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) begin
				lfsr = lfsr ^ 32'hd000_0001;
			end
			v = (v << 1) | int'(b);
		end
		return v;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input axil_pkg::data_t got, input axil_pkg::data_t exp,
		input string what);
		if (got !== exp) begin
			errors++;
			stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_resp(input axil_pkg::resp_t got, input axil_pkg::resp_t exp,
		input string what);
		if (got !== exp) begin
			errors++;
			stop_run($sformatf("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			stop_run($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_range(input axil_pkg::data_t got, input axil_pkg::data_t lo,
		input axil_pkg::data_t hi, input string what);
		if (got < lo || got > hi) begin
			errors++;
			stop_run($sformatf("FAIL %0t: %s got %h outside %h..%h", $time, what, got, lo, hi));
		end
	endtask

	// one read, rready held low for delay cycles once rvalid is up
	task automatic axil_read(input axil_pkg::addr_t addr, input int delay,
		output axil_pkg::data_t data, output axil_pkg::resp_t resp, output int cyc);
		int                n;
		axil_pkg::r_beat_t held;
		n = 0;
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready) begin
			if (n == BUS_TIMEOUT) stop_run("read address channel hung, arready stayed low");
			n++;
			@(posedge clk);
		end
		cyc = cycle_cnt;
		arvalid <= 1'b0;
		n = 0;
		@(posedge clk);
		while (!rvalid) begin
			if (n == BUS_TIMEOUT) stop_run("read data channel hung, rvalid never rose");
			n++;
			@(posedge clk);
		end
		held = r;
		repeat (delay) begin
			@(posedge clk);
			check_level(rvalid, 1'b1, "rvalid under back-pressure");
			check_data(r.data, held.data, "read data under back-pressure");
			check_resp(r.resp, held.resp, "read response under back-pressure");
		end
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		data = held.data;
		resp = held.resp;
	endtask

	// one write with AW and W together, then the B handshake
	task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
		input axil_pkg::strb_t strb, output axil_pkg::resp_t resp, output int cyc);
		int                n;
		axil_pkg::w_beat_t beat;
		n = 0;
		beat.data = data;
		beat.strb = strb;
		awaddr  <= addr;
		w       <= beat;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk);
		while (!(awready && wready)) begin
			if (n == BUS_TIMEOUT) stop_run("write channel hung, awready or wready stayed low");
			n++;
			@(posedge clk);
		end
		cyc = cycle_cnt;
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!bvalid) begin
			if (n == BUS_TIMEOUT) stop_run("write response channel hung, bvalid never rose");
			n++;
			@(posedge clk);
		end
		resp = bresp;
		bready <= 1'b0;
	endtask

	function automatic void add_step(input op_t op, input axil_pkg::addr_t addr,
		input axil_pkg::data_t data, input axil_pkg::strb_t strb,
		input axil_pkg::data_t exp_data, input axil_pkg::resp_t exp_resp, input kind_t kind);
		step_t s;
		s.op       = op;
		s.addr     = addr;
		s.data     = data;
		s.strb     = strb;
		s.exp_data = exp_data;
		s.exp_resp = exp_resp;
		s.kind     = kind;
		steps.push_back(s);
	endfunction

	// level rows carry the expected level in exp_data bit 0
	function automatic void build_table();
		add_step(OP_RD, A_CMP_LO, 32'h0, 4'h0, 32'hffff_ffff, OK, K_EXACT);
		add_step(OP_RD, A_CMP_HI, 32'h0, 4'h0, 32'hffff_ffff, OK, K_EXACT);
		// software interrupt
		add_step(OP_WR, A_MSIP, 32'h1, 4'hf, 32'h1, OK, K_MSIP);
		add_step(OP_RD, A_MSIP, 32'h0, 4'h0, 32'h1, OK, K_EXACT);
		add_step(OP_WR, A_MSIP, 32'hffff_fffe, 4'hf, 32'h0, OK, K_MSIP);
		add_step(OP_RD, A_MSIP, 32'h0, 4'h0, 32'h0, OK, K_EXACT);
		add_step(OP_WR, A_MSIP, 32'h1, 4'b1110, 32'h0, OK, K_MSIP);
		add_step(OP_RD, A_MSIP, 32'h0, 4'h0, 32'h0, OK, K_EXACT);
		// partial strobes on mtimecmp, merged bytewise
		add_step(OP_WR, A_CMP_LO, 32'h1234_5678, 4'b0101, 32'h0, OK, K_EXACT);
		add_step(OP_RD, A_CMP_LO, 32'h0, 4'h0, 32'hff34_ff78, OK, K_EXACT);
		add_step(OP_WR, A_CMP_HI, 32'haabb_ccdd, 4'b1010, 32'h0, OK, K_EXACT);
		add_step(OP_RD, A_CMP_HI, 32'h0, 4'h0, 32'haaff_ccff, OK, K_EXACT);
		add_step(OP_WR, A_CMP_LO, 32'h0, 4'b1010, 32'h0, OK, K_EXACT);
		add_step(OP_RD, A_CMP_LO, 32'h0, 4'h0, 32'h0034_0078, OK, K_EXACT);
		// timer load and advance
		add_step(OP_WR, A_TM_HI, 32'h0, 4'hf, 32'h0, OK, K_EXACT);
		add_step(OP_WR, A_TM_LO, 32'h100, 4'hf, 32'h0, OK, K_BOUND);
		add_step(OP_RD, A_TM_HI, 32'h0, 4'h0, 32'h0, OK, K_EXACT);
		add_step(OP_RD, A_TM_LO, 32'h0, 4'h0, 32'h0, OK, K_BOUND);
		add_step(OP_RD, A_TM_LO, 32'h0, 4'h0, 32'h0, OK, K_BOUND);
		// timer interrupt
		add_step(OP_WR, A_CMP_HI, 32'h0, 4'hf, 32'h0, OK, K_MTIP);
		add_step(OP_WR, A_CMP_LO, 32'h140, 4'hf, 32'h1, OK, K_MTIP);
		add_step(OP_WR, A_CMP_HI, 32'hffff_ffff, 4'hf, 32'h0, OK, K_MTIP);
		add_step(OP_WR, A_CMP_LO, 32'hffff_ffff, 4'hf, 32'h0, OK, K_MTIP);
		// unmapped access
		add_step(OP_WR, A_MSIP, 32'h1, 4'hf, 32'h1, OK, K_MSIP);
		add_step(OP_RD, A_BAD, 32'h0, 4'h0, 32'h0, ERR, K_EXACT);
		add_step(OP_WR, A_BAD, 32'h0, 4'hf, 32'h1, ERR, K_MSIP);
		add_step(OP_RD, A_MSIP, 32'h0, 4'h0, 32'h1, OK, K_EXACT);
		add_step(OP_RD, A_CMP_LO, 32'h0, 4'h0, 32'hffff_ffff, OK, K_EXACT);
		add_step(OP_RD, A_CMP_HI, 32'h0, 4'h0, 32'hffff_ffff, OK, K_EXACT);
	endfunction

	initial begin
		step_t           st;
		axil_pkg::data_t data;
		axil_pkg::resp_t resp;
		axil_pkg::data_t ref_val;
		int              cyc;
		int              ref_cyc;
		int              lim;
		int              n;
		logic            level;
		rst     <= 1'b1;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		awaddr  <= '0;
		awvalid <= 1'b0;
		w       <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		ref_val = '0;
		ref_cyc = 0;
		build_table();
		repeat (5) @(posedge clk);
		check_level(arready, 1'b0, "arready in reset");
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		check_level(arready, 1'b1, "arready after reset");
		check_level(awready, 1'b1, "awready after reset");
		check_level(wready, 1'b1, "wready after reset");
		check_level(rvalid, 1'b0, "rvalid after reset");
		check_level(bvalid, 1'b0, "bvalid after reset");
		check_level(msip, 1'b0, "msip after reset");
		check_level(mtip, 1'b0, "mtip after reset");
		foreach (steps[i]) begin
			st = steps[i];
			if (st.op == OP_WR) begin
				axil_write(st.addr, st.data, st.strb, resp, cyc);
				check_resp(resp, st.exp_resp, $sformatf("step %0d write response", i));
			end else begin
				axil_read(st.addr, rand_bits(3), data, resp, cyc);
				check_resp(resp, st.exp_resp, $sformatf("step %0d read response", i));
				if (st.kind == K_EXACT) begin
					check_data(data, st.exp_data, $sformatf("step %0d read data", i));
				end
			end
			case (st.kind)
				K_BOUND: begin
					// at most one tick per TICK_DIV cycles since the reference point
					if (st.op == OP_RD) begin
						check_range(data, ref_val,
							ref_val + axil_pkg::data_t'((cyc - ref_cyc) / TICK_DIV + 1),
							$sformatf("step %0d mtime advance", i));
						ref_val = data;
					end else begin
						ref_val = st.data;
					end
					ref_cyc = cyc;
				end
				K_MSIP, K_MTIP: begin
					lim   = st.exp_data[0] ? LEVEL_TIMEOUT : 2;
					n     = 0;
					level = (st.kind == K_MSIP) ? msip : mtip;
					while (level !== st.exp_data[0] && n < lim) begin
						@(posedge clk);
						n++;
						level = (st.kind == K_MSIP) ? msip : mtip;
					end
					check_level(level, st.exp_data[0], $sformatf("step %0d interrupt level", i));
				end
				default: ;
			endcase
		end
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== src/clint_top.sv ====
// CLINT top level for one hart; AXI-Lite slave port in, msip and mtip levels out
`timescale 1ns/10ps

module clint_top #(
	parameter axil_pkg::addr_t CLINT_BASE = 32'h0200_0000,
	parameter int              TICK_DIV   = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  axil_pkg::addr_t   araddr,
	input  logic              arvalid,
	output logic              arready,
	output axil_pkg::r_beat_t r,
	output logic              rvalid,
	input  logic              rready,
	input  axil_pkg::addr_t   awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  axil_pkg::w_beat_t w,
	input  logic              wvalid,
	output logic              wready,
	output axil_pkg::resp_t   bresp,
	output logic              bvalid,
	input  logic              bready,
	output logic              msip,
	output logic              mtip
);

	axil_pkg::addr_t     rd_addr;
	logic                rd_hit;
	axil_pkg::data_t     rd_data;
	axil_pkg::addr_t     wr_addr;
	clint_pkg::reg_sel_t wr_sel;
	logic                wr_hit;
	clint_pkg::reg_wr_t  wr_req;
	clint_pkg::reg_wr_t  time_wr;
	clint_pkg::mtime_t   mtime_value;
	clint_pkg::mtime_t   mtimecmp;

	clint_read_fsm i_read_fsm (
		.clk, .rst,
		.araddr, .arvalid, .arready,
		.r, .rvalid, .rready,
		.rd_addr, .rd_hit, .rd_data
	);

	clint_write_fsm i_write_fsm (
		.clk, .rst,
		.awaddr, .awvalid, .awready,
		.w, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.wr_addr, .wr_sel, .wr_hit, .wr_req
	);

	clint_regs #(
		.CLINT_BASE(CLINT_BASE)
	) i_regs (
		.clk, .rst,
		.rd_addr, .rd_hit, .rd_data,
		.wr_addr, .wr_sel, .wr_hit, .wr_req,
		.mtime_value, .mtimecmp, .time_wr, .msip
	);

	clint_mtime #(
		.TICK_DIV(TICK_DIV)
	) i_mtime (
		.clk, .rst,
		.time_wr, .mtimecmp, .mtime_value, .mtip
	);

endmodule

// ==== src/clint_write_fsm.sv ====
// AXI-Lite write channel of the CLINT; takes AW and W together and returns the B response
`timescale 1ns/10ps

module clint_write_fsm (
	input  logic                clk,
	input  logic                rst,
	input  axil_pkg::addr_t     awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  axil_pkg::w_beat_t   w,
	input  logic                wvalid,
	output logic                wready,
	output axil_pkg::resp_t     bresp,
	output logic                bvalid,
	input  logic                bready,
	output axil_pkg::addr_t     wr_addr,
	input  clint_pkg::reg_sel_t wr_sel,
	input  logic                wr_hit,
	output clint_pkg::reg_wr_t  wr_req
);

	clint_pkg::wr_state_t state;
	logic                 ready_q;
	axil_pkg::resp_t      bresp_q;
	logic                 aw_fire;
	logic                 b_fire;

	// address and data must arrive in the same cycle
	assign aw_fire = awvalid && wvalid && ready_q;
	assign b_fire  = bvalid && bready;

	assign wr_addr = awaddr;

	// register file updates on the accepting edge
	assign wr_req.en   = aw_fire;
	assign wr_req.sel  = wr_sel;
	assign wr_req.beat = w;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= clint_pkg::WR_IDLE;
			ready_q <= 1'b0;
		end else begin
			case (state)
				clint_pkg::WR_IDLE: begin
					if (aw_fire) begin
						state   <= clint_pkg::WR_RESP;
						ready_q <= 1'b0;
					end else begin
						ready_q <= 1'b1;
					end
				end
				clint_pkg::WR_RESP: begin
					if (b_fire) begin
						state   <= clint_pkg::WR_IDLE;
						ready_q <= 1'b1;
					end
				end
				default: state <= clint_pkg::WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			bresp_q <= wr_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
		end
	end

	assign awready = ready_q;
	assign wready  = ready_q;
	assign bvalid  = (state == clint_pkg::WR_RESP);
	assign bresp   = bresp_q;

	// no new write is accepted while a response is pending
	a_no_accept_in_resp: assert property (@(posedge clk) disable iff (rst)
		!(awready && bvalid));

	// response held under back-pressure
	a_b_stable: assert property (@(posedge clk) disable iff (rst)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)));

endmodule

// ==== src/clint_read_fsm.sv ====
// AXI-Lite read channel of the CLINT; samples the register data at the AR handshake
`timescale 1ns/10ps

module clint_read_fsm (
	input  logic              clk,
	input  logic              rst,
	input  axil_pkg::addr_t   araddr,
	input  logic              arvalid,
	output logic              arready,
	output axil_pkg::r_beat_t r,
	output logic              rvalid,
	input  logic              rready,
	output axil_pkg::addr_t   rd_addr,
	input  logic              rd_hit,
	input  axil_pkg::data_t   rd_data
);

	clint_pkg::rd_state_t state;
	logic                 arready_q;
	axil_pkg::r_beat_t    r_q;
	logic                 ar_fire;
	logic                 r_fire;

	assign ar_fire = arvalid && arready_q;
	assign r_fire  = rvalid && rready;

	// decode is done in the register file
	assign rd_addr = araddr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= clint_pkg::RD_IDLE;
			arready_q <= 1'b0;
		end else begin
			case (state)
				clint_pkg::RD_IDLE: begin
					if (ar_fire) begin
						state     <= clint_pkg::RD_RESP;
						arready_q <= 1'b0;
					end else begin
						arready_q <= 1'b1;
					end
				end
				clint_pkg::RD_RESP: begin
					// no new address until the data has gone out
					if (r_fire) begin
						state     <= clint_pkg::RD_IDLE;
						arready_q <= 1'b1;
					end
				end
				default: state <= clint_pkg::RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == clint_pkg::RD_IDLE && ar_fire) begin
			if (rd_hit) begin
				r_q.data <= rd_data;
				r_q.resp <= axil_pkg::RESP_OKAY;
			end else begin
				r_q.data <= '0;
				r_q.resp <= axil_pkg::RESP_SLVERR;
			end
		end
	end

	assign arready = arready_q;
	assign rvalid  = (state == clint_pkg::RD_RESP);
	assign r       = r_q;

	a_rvalid_after_ar: assert property (@(posedge clk) disable iff (rst)
		$rose(rvalid) |-> $past(arvalid && arready));

	// beat held under back-pressure
	a_r_stable: assert property (@(posedge clk) disable iff (rst)
		(state == clint_pkg::RD_RESP && !rready) |=>
		(state == clint_pkg::RD_RESP && $stable(r)));

endmodule

// ==== src/clint_regs.sv ====
// CLINT register file: address decode, msip and mtimecmp storage, mtime forwarding, read mux
`timescale 1ns/10ps

module clint_regs #(
	parameter axil_pkg::addr_t CLINT_BASE = 32'h0200_0000
) (
	input  logic                 clk,
	input  logic                 rst,
	input  axil_pkg::addr_t      rd_addr,
	output logic                 rd_hit,
	output axil_pkg::data_t      rd_data,
	input  axil_pkg::addr_t      wr_addr,
	output clint_pkg::reg_sel_t  wr_sel,
	output logic                 wr_hit,
	input  clint_pkg::reg_wr_t   wr_req,
	input  clint_pkg::mtime_t    mtime_value,
	output clint_pkg::mtime_t    mtimecmp,
	output clint_pkg::reg_wr_t   time_wr,
	output logic                 msip
);

	clint_pkg::reg_sel_t rd_sel;
	logic                msip_q;
	clint_pkg::mtime_t   mtimecmp_q;

	function automatic clint_pkg::reg_sel_t decode(axil_pkg::addr_t addr);
		clint_pkg::reg_sel_t sel;
		case (addr)
			CLINT_BASE + clint_pkg::OFS_MSIP:        sel = clint_pkg::SEL_MSIP;
			CLINT_BASE + clint_pkg::OFS_MTIMECMP_LO: sel = clint_pkg::SEL_CMP_LO;
			CLINT_BASE + clint_pkg::OFS_MTIMECMP_HI: sel = clint_pkg::SEL_CMP_HI;
			CLINT_BASE + clint_pkg::OFS_MTIME_LO:    sel = clint_pkg::SEL_TIME_LO;
			CLINT_BASE + clint_pkg::OFS_MTIME_HI:    sel = clint_pkg::SEL_TIME_HI;
			default:                                 sel = clint_pkg::SEL_NONE;
		endcase
		return sel;
	endfunction

	assign rd_sel = decode(rd_addr);
	assign rd_hit = (rd_sel != clint_pkg::SEL_NONE);
	assign wr_sel = decode(wr_addr);
	assign wr_hit = (wr_sel != clint_pkg::SEL_NONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			msip_q     <= 1'b0;
			mtimecmp_q <= '1;
		end else if (wr_req.en) begin
			case (wr_req.sel)
				clint_pkg::SEL_MSIP: begin
					// only bit 0 is implemented
					if (wr_req.beat.strb[0]) begin
						msip_q <= wr_req.beat.data[0];
					end
				end
				clint_pkg::SEL_CMP_LO:
					mtimecmp_q[31:0] <= axil_pkg::strb_merge(mtimecmp_q[31:0], wr_req.beat);
				clint_pkg::SEL_CMP_HI:
					mtimecmp_q[63:32] <= axil_pkg::strb_merge(mtimecmp_q[63:32], wr_req.beat);
				default: ;
			endcase
		end
	end

	// timer writes go on to clint_mtime
	always_comb begin
		time_wr    = wr_req;
		time_wr.en = wr_req.en && (wr_req.sel == clint_pkg::SEL_TIME_LO ||
			wr_req.sel == clint_pkg::SEL_TIME_HI);
	end

	always_comb begin
		case (rd_sel)
			clint_pkg::SEL_MSIP:    rd_data = {31'd0, msip_q};
			clint_pkg::SEL_CMP_LO:  rd_data = mtimecmp_q[31:0];
			clint_pkg::SEL_CMP_HI:  rd_data = mtimecmp_q[63:32];
			clint_pkg::SEL_TIME_LO: rd_data = mtime_value[31:0];
			clint_pkg::SEL_TIME_HI: rd_data = mtime_value[63:32];
			default:                rd_data = '0;
		endcase
	end

	assign mtimecmp = mtimecmp_q;
	assign msip     = msip_q;

endmodule

// ==== src/clint_mtime.sv ====
// machine timer mtime with tick prescaler, software load and the registered mtip compare
`timescale 1ns/10ps

module clint_mtime #(
	parameter int TICK_DIV = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  clint_pkg::reg_wr_t time_wr,
	input  clint_pkg::mtime_t  mtimecmp,
	output clint_pkg::mtime_t  mtime_value,
	output logic             mtip
);

	// at least one bit even when every cycle is a tick
	localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	clint_pkg::mtime_t mtime_q;
	logic [PW-1:0]     presc_q;
	logic              tick;
	logic              load;
	logic              mtip_q;

	assign tick = (presc_q == PW'(TICK_DIV - 1));
	assign load = time_wr.en;

	always_ff @(posedge clk) begin
		if (rst) begin
			mtime_q <= '0;
			presc_q <= '0;
			mtip_q  <= 1'b0;
		end else begin
			mtip_q <= (mtime_q >= mtimecmp);
			if (load) begin
				// a load restarts the prescaler
				presc_q <= '0;
				if (time_wr.sel == clint_pkg::SEL_TIME_HI) begin
					mtime_q[63:32] <= axil_pkg::strb_merge(mtime_q[63:32], time_wr.beat);
				end else begin
					mtime_q[31:0] <= axil_pkg::strb_merge(mtime_q[31:0], time_wr.beat);
				end
			end else if (tick) begin
				presc_q <= '0;
				mtime_q <= mtime_q + 64'd1;
			end else begin
				presc_q <= presc_q + PW'(1);
			end
		end
	end

	assign mtime_value = mtime_q;
	assign mtip        = mtip_q;

	// only a software load may move the timer backwards
	a_mtime_monotonic: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && !$past(load)) |-> (mtime_q >= $past(mtime_q)));

endmodule

// ==== src/clint_pkg.sv ====
// CLINT register map, timer type, register select and FSM states used across the CLINT
package clint_pkg;

	typedef logic [63:0] mtime_t;

	// offsets from the CLINT base, single hart
	localparam axil_pkg::addr_t OFS_MSIP        = 32'h0000_0000;
	localparam axil_pkg::addr_t OFS_MTIMECMP_LO = 32'h0000_4000;
	localparam axil_pkg::addr_t OFS_MTIMECMP_HI = 32'h0000_4004;
	localparam axil_pkg::addr_t OFS_MTIME_LO    = 32'h0000_bff8;
	localparam axil_pkg::addr_t OFS_MTIME_HI    = 32'h0000_bffc;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_MSIP,
		SEL_CMP_LO,
		SEL_CMP_HI,
		SEL_TIME_LO,
		SEL_TIME_HI
	} reg_sel_t;

	// one decoded register write, en is a single-cycle strobe
	typedef struct packed {
		logic              en;
		reg_sel_t          sel;
		axil_pkg::w_beat_t beat;
	} reg_wr_t;

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} rd_state_t;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_t;

endpackage

// ==== src/axil_pkg.sv ====
// AXI-Lite bus types and the byte-strobe merge helper shared by the CLINT channels
package axil_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// read data beat, data in the upper bits
	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_beat_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_beat_t;

	// replace only the bytes enabled in the strobe
	function automatic data_t strb_merge(data_t old_data, w_beat_t beat);
		data_t merged;
		merged = old_data;
		for (int i = 0; i < $bits(strb_t); i++) begin
			if (beat.strb[i]) begin
				merged[8*i +: 8] = beat.data[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage
